// ==== common/riscPkg.sv ====
package riscPkg;

    typedef logic [31:0] wordT;     // Data or instruction word
    typedef logic [4:0]  regAddrT;  // Register file index

    // Opcode field, bits 31:26
    typedef enum logic [5:0] {
        ADD   = 6'd0,
        SUB   = 6'd1,
        AND   = 6'd2,
        OR    = 6'd3,
        SLT   = 6'd4,
        MUL   = 6'd5,
        LW    = 6'd8,
        SW    = 6'd9,
        ADDI  = 6'd10,
        SUBI  = 6'd11,
        SLTI  = 6'd12,
        BNEQZ = 6'd13,
        BEQZ  = 6'd14,
        HLT   = 6'd63
    } opcodeT;

    typedef enum logic [2:0] {
        RR_ALU    = 3'd0,
        RM_ALU    = 3'd1,
        LOAD      = 3'd2,
        STORE     = 3'd3,
        BRANCH    = 3'd4,
        HALT      = 3'd5,
        NOP_CLASS = 3'd6    // Bubble
    } instrClassT;

endpackage

// ==== riscCore/riscFetch.sv ====
`timescale 1ns/10ps

module riscFetch (
    input  logic           clk1,
    input  logic           rstN,
    input  logic           run,
    input  logic           halted,
    input  logic           branchTaken,
    input  riscPkg::wordT  branchTarget,
    input  riscPkg::wordT  fetchData,
    output riscPkg::wordT  fetchAddr,
    output riscPkg::wordT  ifIr,
    output riscPkg::wordT  ifNpc,
    output logic           ifValid
);

    riscPkg::wordT pc;

    assign fetchAddr = pc;

    always_ff @(posedge clk1) begin
        if (!rstN || !run) begin
            pc      <= '0;          // Start from address 0 when run rises
            ifValid <= 1'b0;
        end else if (!halted) begin
            if (branchTaken) begin
                pc      <= branchTarget;
                ifValid <= 1'b0;    // Word fetched this cycle is wrong path
            end else begin
                pc      <= pc + 32'd1;
                ifValid <= 1'b1;
            end
        end
    end

    // IF/ID payload
    always_ff @(posedge clk1) begin
        if (!halted) begin
            ifIr  <= fetchData;
            ifNpc <= pc + 32'd1;
        end
    end

endmodule

// ==== riscCore/riscDecode.sv ====
`timescale 1ns/10ps

module riscDecode (
    input  logic                 clk1,
    input  logic                 rstN,
    input  logic                 run,
    input  logic                 halted,
    input  riscPkg::wordT        ifIr,
    input  riscPkg::wordT        ifNpc,
    input  logic                 ifValid,
    input  logic                 branchTaken,
    input  logic                 wbWe,
    input  riscPkg::regAddrT     wbAddr,
    input  riscPkg::wordT        wbData,
    output riscPkg::wordT        idIr,
    output riscPkg::wordT        idNpc,
    output riscPkg::wordT        idA,
    output riscPkg::wordT        idB,
    output riscPkg::wordT        idImm,
    output riscPkg::instrClassT  idClass
);

    riscPkg::wordT       regFile [32];
    riscPkg::regAddrT    rs;
    riscPkg::regAddrT    rt;
    riscPkg::wordT       rsData;
    riscPkg::wordT       rtData;
    riscPkg::instrClassT decClass;

    assign rs = ifIr[25:21];
    assign rt = ifIr[20:16];

    // r0 reads zero and a same-cycle write bypasses the file
    assign rsData = (rs == '0) ? '0 :
                    (wbWe && wbAddr == rs) ? wbData : regFile[rs];
    assign rtData = (rt == '0) ? '0 :
                    (wbWe && wbAddr == rt) ? wbData : regFile[rt];

    always_ff @(posedge clk1) begin
        if (wbWe && wbAddr != '0) begin
            regFile[wbAddr] <= wbData;
        end
    end

    always_comb begin
        case (ifIr[31:26])
            riscPkg::ADD, riscPkg::SUB, riscPkg::AND,
            riscPkg::OR, riscPkg::SLT, riscPkg::MUL:  decClass = riscPkg::RR_ALU;
            riscPkg::ADDI, riscPkg::SUBI, riscPkg::SLTI: decClass = riscPkg::RM_ALU;
            riscPkg::LW:                              decClass = riscPkg::LOAD;
            riscPkg::SW:                              decClass = riscPkg::STORE;
            riscPkg::BNEQZ, riscPkg::BEQZ:            decClass = riscPkg::BRANCH;
            default:                                  decClass = riscPkg::HALT; // HLT and undefined
        endcase
    end

    always_ff @(posedge clk1) begin
        if (!rstN || !run) begin
            idClass <= riscPkg::NOP_CLASS;
        end else if (!halted) begin
            idClass <= (!ifValid || branchTaken) ? riscPkg::NOP_CLASS : decClass;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk1) begin
        if (!halted) begin
            idIr  <= ifIr;
            idNpc <= ifNpc;
            idA   <= rsData;
            idB   <= rtData;
            idImm <= {{16{ifIr[15]}}, ifIr[15:0]};
        end
    end

endmodule

// ==== riscCore/riscExecute.sv ====
`timescale 1ns/10ps

module riscExecute (
    input  logic                 clk1,
    input  logic                 rstN,
    input  logic                 halted,
    input  riscPkg::wordT        idIr,
    input  riscPkg::wordT        idNpc,
    input  riscPkg::wordT        idA,
    input  riscPkg::wordT        idB,
    input  riscPkg::wordT        idImm,
    input  riscPkg::instrClassT  idClass,
    output riscPkg::wordT        exIr,
    output riscPkg::wordT        exAlu,
    output riscPkg::wordT        exB,
    output riscPkg::instrClassT  exClass,
    output logic                 branchTaken,
    output riscPkg::wordT        branchTarget
);

    logic [5:0]    op;
    riscPkg::wordT aluOut;

    assign op           = idIr[31:26];
    assign branchTarget = idNpc + idImm;
    assign branchTaken  = (idClass == riscPkg::BRANCH) &&
                          (((op == riscPkg::BEQZ) && (idA == '0)) ||
                           ((op == riscPkg::BNEQZ) && (idA != '0)));

    always_comb begin
        aluOut = '0;
        case (idClass)
            riscPkg::RR_ALU: begin
                case (op)
                    riscPkg::ADD: aluOut = idA + idB;
                    riscPkg::SUB: aluOut = idA - idB;
                    riscPkg::AND: aluOut = idA & idB;
                    riscPkg::OR:  aluOut = idA | idB;
                    riscPkg::SLT: aluOut = {31'd0, $signed(idA) < $signed(idB)};
                    riscPkg::MUL: aluOut = idA * idB;   // Low word only
                    default:      aluOut = '0;
                endcase
            end
            riscPkg::RM_ALU: begin
                case (op)
                    riscPkg::ADDI: aluOut = idA + idImm;
                    riscPkg::SUBI: aluOut = idA - idImm;
                    riscPkg::SLTI: aluOut = {31'd0, $signed(idA) < $signed(idImm)};
                    default:       aluOut = '0;
                endcase
            end
            riscPkg::LOAD, riscPkg::STORE: aluOut = idA + idImm;   // Effective address
            riscPkg::BRANCH:               aluOut = branchTarget;
            default:                       aluOut = '0;
        endcase
    end

    always_ff @(posedge clk1) begin
        if (!rstN) begin
            exClass <= riscPkg::NOP_CLASS;
        end else if (!halted) begin
            exClass <= branchTaken ? riscPkg::NOP_CLASS : idClass;
        end
    end

    // EX/MEM payload
    always_ff @(posedge clk1) begin
        if (!halted) begin
            exIr  <= idIr;
            exAlu <= aluOut;
            exB   <= idB;
        end
    end

endmodule

// ==== riscCore/riscMemWb.sv ====
`timescale 1ns/10ps

module riscMemWb (
    input  logic                 clk1,
    input  logic                 rstN,
    input  riscPkg::wordT        exIr,
    input  riscPkg::wordT        exAlu,
    input  riscPkg::wordT        exB,
    input  riscPkg::instrClassT  exClass,
    input  riscPkg::wordT        dataRdData,
    output riscPkg::wordT        dataAddr,
    output riscPkg::wordT        dataWrData,
    output logic                 dataWe,
    output logic                 wbWe,
    output riscPkg::regAddrT     wbAddr,
    output riscPkg::wordT        wbData,
    output logic                 halted
);

    riscPkg::instrClassT wbClass;

    assign dataAddr   = exAlu;
    assign dataWrData = exB;
    // A store right behind HLT must not land while halted is still rising
    assign dataWe     = (exClass == riscPkg::STORE) && !halted &&
                        (wbClass != riscPkg::HALT);

    assign wbWe = !halted && ((wbClass == riscPkg::RR_ALU) ||
                              (wbClass == riscPkg::RM_ALU) ||
                              (wbClass == riscPkg::LOAD));

    always_ff @(posedge clk1) begin
        if (!rstN) begin
            wbClass <= riscPkg::NOP_CLASS;
            halted  <= 1'b0;
        end else begin
            if (!halted) begin
                wbClass <= exClass;
            end
            if (wbClass == riscPkg::HALT) begin
                halted <= 1'b1;     // Sticky until reset
            end
        end
    end

    // MEM/WB payload
    always_ff @(posedge clk1) begin
        if (!halted) begin
            wbAddr <= (exClass == riscPkg::RR_ALU) ? exIr[15:11] : exIr[20:16];
            wbData <= (exClass == riscPkg::LOAD) ? dataRdData : exAlu;
        end
    end

endmodule

// ==== source/riscMemory.sv ====
`timescale 1ns/10ps

module riscMemory #(
    parameter int memAddrBits = 10
) (
    input  logic           clk1,
    input  logic           rstN,
    input  logic           coreActive,
    input  riscPkg::wordT  fetchAddr,
    input  riscPkg::wordT  dataAddr,
    input  riscPkg::wordT  dataWrData,
    input  logic           dataWe,
    input  logic           hostReq,
    input  logic           hostWe,
    input  riscPkg::wordT  hostAddr,
    input  riscPkg::wordT  hostWrData,
    output riscPkg::wordT  fetchData,
    output riscPkg::wordT  dataRdData,
    output riscPkg::wordT  hostRdData,
    output logic           hostAck
);

    typedef enum logic {
        HOST_IDLE,
        HOST_ACKED
    } hostStateT;

    riscPkg::wordT mem [2**memAddrBits];
    hostStateT     hostState;
    logic          hostGo;

    assign fetchData  = mem[fetchAddr[memAddrBits-1:0]];
    assign dataRdData = mem[dataAddr[memAddrBits-1:0]];

    // Host waits here until the core is idle
    assign hostGo  = (hostState == HOST_IDLE) && hostReq && !coreActive;
    assign hostAck = (hostState == HOST_ACKED);

    always_ff @(posedge clk1) begin
        if (!rstN) begin
            hostState <= HOST_IDLE;
        end else begin
            case (hostState)
                HOST_IDLE:  if (hostGo) hostState <= HOST_ACKED;
                HOST_ACKED: if (!hostReq) hostState <= HOST_IDLE;
                default:    hostState <= HOST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk1) begin
        if (dataWe) begin
            mem[dataAddr[memAddrBits-1:0]] <= dataWrData;
        end else if (hostGo && hostWe) begin
            mem[hostAddr[memAddrBits-1:0]] <= hostWrData;
        end
    end

    // Read data held while hostAck is high
    always_ff @(posedge clk1) begin
        if (hostGo) begin
            hostRdData <= mem[hostAddr[memAddrBits-1:0]];
        end
    end

endmodule

// ==== source/riscTop.sv ====
`timescale 1ns/10ps

module riscTop #(
    parameter int memAddrBits = 10
) (
    input  logic           clk1,
    input  logic           rstN,
    input  logic           run,
    input  logic           hostReq,
    input  logic           hostWe,
    input  riscPkg::wordT  hostAddr,
    input  riscPkg::wordT  hostWrData,
    output logic           hostAck,
    output riscPkg::wordT  hostRdData,
    output logic           halted
);

    riscPkg::wordT       fetchAddr, fetchData;
    riscPkg::wordT       ifIr, ifNpc;
    logic                ifValid;
    riscPkg::wordT       idIr, idNpc, idA, idB, idImm;
    riscPkg::instrClassT idClass;
    riscPkg::wordT       exIr, exAlu, exB;
    riscPkg::instrClassT exClass;
    logic                branchTaken;
    riscPkg::wordT       branchTarget;
    riscPkg::wordT       dataAddr, dataWrData, dataRdData;
    logic                dataWe;
    logic                wbWe;
    riscPkg::regAddrT    wbAddr;
    riscPkg::wordT       wbData;
    logic                coreActive;

    assign coreActive = run && !halted;

    riscFetch iFetch (
        .clk1, .rstN, .run, .halted, .branchTaken, .branchTarget,
        .fetchData, .fetchAddr, .ifIr, .ifNpc, .ifValid
    );

    riscDecode iDecode (
        .clk1, .rstN, .run, .halted, .ifIr, .ifNpc, .ifValid, .branchTaken,
        .wbWe, .wbAddr, .wbData,
        .idIr, .idNpc, .idA, .idB, .idImm, .idClass
    );

    riscExecute iExecute (
        .clk1, .rstN, .halted, .idIr, .idNpc, .idA, .idB, .idImm, .idClass,
        .exIr, .exAlu, .exB, .exClass, .branchTaken, .branchTarget
    );

    riscMemWb iMemWb (
        .clk1, .rstN, .exIr, .exAlu, .exB, .exClass, .dataRdData,
        .dataAddr, .dataWrData, .dataWe, .wbWe, .wbAddr, .wbData, .halted
    );

    riscMemory #(.memAddrBits(memAddrBits)) iMemory (
        .clk1, .rstN, .coreActive, .fetchAddr, .dataAddr, .dataWrData, .dataWe,
        .hostReq, .hostWe, .hostAddr, .hostWrData,
        .fetchData, .dataRdData, .hostRdData, .hostAck
    );

endmodule

// ==== testbench/riscTopTb.sv ====
`timescale 1ns/10ps

module riscTopTb;

    logic          clk1;
    logic          rstN;
    logic          run;
    logic          hostReq;
    logic          hostWe;
    riscPkg::wordT hostAddr;
    riscPkg::wordT hostWrData;
    logic          hostAck;
    riscPkg::wordT hostRdData;
    logic          halted;

    riscPkg::wordT loadAddr[$];
    riscPkg::wordT loadData[$];
    riscPkg::wordT expAddr[$];
    riscPkg::wordT expData[$];
    int            errors = 0;
    int            cycles = 0;
    int            limit = 100000;   // Replaced once the stimulus is read

    riscTop #(.memAddrBits(10)) i_riscTop (
        .clk1, .rstN, .run, .hostReq, .hostWe, .hostAddr, .hostWrData,
        .hostAck, .hostRdData, .halted
    );

    initial clk1 = 1'b0;
    always #5 clk1 = ~clk1;

    always @(posedge clk1) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout after %0d cycles, no hostAck or halt", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic checkWord(input riscPkg::wordT got, input riscPkg::wordT exp,
                             input string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkFlag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Four-phase access that waits for hostAck before releasing the request
    task automatic hostAccess(input logic we, input riscPkg::wordT addr,
                              input riscPkg::wordT wrData, output riscPkg::wordT rdData);
        @(posedge clk1);
        hostReq    <= 1'b1;
        hostWe     <= we;
        hostAddr   <= addr;
        hostWrData <= wrData;
        @(negedge clk1);
        while (!hostAck) begin
            @(negedge clk1);
        end
        rdData = hostRdData;
        @(posedge clk1);
        hostReq <= 1'b0;
        @(posedge clk1);
        @(negedge clk1);
        checkFlag(hostAck, 1'b0, "hostAck one cycle after hostReq drop");
    endtask

    task automatic readStim();
        int            fd;
        int            n;
        string         line;
        byte           kind;
        riscPkg::wordT a;
        riscPkg::wordT w;
        fd = $fopen("testbench/riscStim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open testbench/riscStim.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%c %h %h", kind, a, w);
                    if (n == 3 && kind == "L") begin
                        loadAddr.push_back(a);
                        loadData.push_back(w);
                    end else if (n == 3 && kind == "E") begin
                        expAddr.push_back(a);
                        expData.push_back(w);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        riscPkg::wordT rd;
        hostReq    <= 1'b0;
        hostWe     <= 1'b0;
        hostAddr   <= '0;
        hostWrData <= '0;
        run        <= 1'b0;
        rstN       <= 1'b0;
        readStim();
        limit = 20 * loadAddr.size() + 10 * (loadAddr.size() + expAddr.size() + 3) + 20;
        repeat (5) @(posedge clk1);
        rstN <= 1'b1;
        @(negedge clk1);
        checkFlag(hostAck, 1'b0, "hostAck after reset");
        checkFlag(halted, 1'b0, "halted after reset");

        // Host write then read back of a spare word
        hostAccess(1'b1, 32'h3F0, 32'hCAFE_F00D, rd);
        hostAccess(1'b0, 32'h3F0, 32'h0, rd);
        checkWord(rd, 32'hCAFE_F00D, "host readback of 0x3f0");

        foreach (loadAddr[i]) begin
            hostAccess(1'b1, loadAddr[i], loadData[i], rd);
        end

        @(posedge clk1);
        run <= 1'b1;
        // Memory holds a request made while running until the halt
        hostAccess(1'b0, 32'h120, 32'h0, rd);
        checkFlag(halted, 1'b1, "halted when host read was acknowledged");

        foreach (expAddr[i]) begin
            hostAccess(1'b0, expAddr[i], 32'h0, rd);
            checkWord(rd, expData[i], $sformatf("mem[%h]", expAddr[i]));
        end

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== testbench/riscStim.txt ====
# L addr word: host loads word into memory before run
# E addr word: expected memory word after halt
L 000 20010100
L 001 20020101
L 002 00000000
L 003 00000000
L 004 00221800
L 005 04222000
L 006 08222800
L 007 0C223000
L 008 10413800
L 009 14224000
L 00A 2829FFFB
L 00B 2C2A000A
L 00C 302B0008
L 00D 200C0102
L 00E 00220000
L 00F 00000000
L 010 24030110
L 011 24040111
L 012 24050112
L 013 24060113
L 014 24070114
L 015 24080115
L 016 24090116
L 017 240A0117
L 018 240B0118
L 019 240C0119
L 01A 2400011A
L 01B 38000002
L 01C 2403011B
L 01D 2403011C
L 01E 34200002
L 01F 2403011D
L 020 2403011E
L 021 38200000
L 022 2404011F
L 023 FC000000
L 024 24030120
L 025 00000000
L 026 00000000
L 100 00000007
L 101 00000003
L 102 12345678
L 11A FFFFFFFF
L 11B AAAA0001
L 11C AAAA0002
L 11D AAAA0003
L 11E AAAA0004
L 11F 00000000
L 120 55555555
E 110 0000000A
E 111 00000004
E 112 00000003
E 113 00000007
E 114 00000001
E 115 00000015
E 116 00000002
E 117 FFFFFFFD
E 118 00000001
E 119 12345678
E 11A 00000000
E 11B AAAA0001
E 11C AAAA0002
E 11D AAAA0003
E 11E AAAA0004
E 11F 00000004
E 120 55555555
E 102 12345678

// ==== sim.f ====
common/riscPkg.sv
riscCore/riscFetch.sv
riscCore/riscDecode.sv
riscCore/riscExecute.sv
riscCore/riscMemWb.sv
source/riscMemory.sv
source/riscTop.sv
testbench/riscTopTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary -f sim.f --top-module riscTopTb -o riscSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/riscSim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Simulation finished: PASS"; then
    exit 0
fi
exit 1
